//--- logic/sensor_link_settings.svh
// sensor link settings
// protocol magic, version bytes, buffer size and the request and reply
// lengths shared by the card-side adapter blocks

`ifndef SENSOR_LINK_SETTINGS_SVH
`define SENSOR_LINK_SETTINGS_SVH

// ============================================================
// protocol identity
// ============================================================

// sent and expected little endian, LSB first on the wire
`define SL_MAGIC                32'hd3a5_6c19

// version bytes reported by IDENTIFY
`define SL_PROTOCOL_VERSION     8'h01
`define SL_ADAPTER_VERSION      8'h03
// upper nibble digital core, lower nibble analog front end
`define SL_CORE_VERSION         8'h12
// upper nibble sensor, lower nibble ADC
`define SL_SENSOR_VERSION       8'h21

// ============================================================
// sizes
// ============================================================

// header plus the largest argument block, CRC not stored
`define SL_RX_BUFF_LEN          7

// request lengths as counted on the wire, CRC included
`define SL_REQ_LEN_SHORT        4'd7
`define SL_REQ_LEN_SET_SIGNAL   4'd9

// reply lengths, 5 byte header plus payload
`define SL_REPLY_LEN_IDENTIFY   4'd9
`define SL_REPLY_LEN_RESULT     4'd8
`define SL_REPLY_LEN_STATUS     4'd6

`endif

//--- logic/sensor_link_pkg.sv
// sensor link types
// command codes, sensor control word, status flags and the two ways
// the 4-byte reply payload word is built

`default_nettype none

package sensor_link_pkg;

    // command byte of a request, echoed in the reply
    // code 2 is not implemented and decodes as unknown
    typedef enum logic [7:0] {
        CMD_IDENTIFY   = 8'd0,
        CMD_SET_SIGNAL = 8'd1,
        CMD_GET_RESULT = 8'd3,
        CMD_ABORT      = 8'd4
    } command_e;

    // sensor and ADC control lines, listed MSB first
    typedef struct packed {
        logic       spare;
        logic       adc_read;
        logic       adc_enable;
        logic       sens_read;
        logic       sens_enable;
        logic [2:0] sens_config;
    } sensor_signals_t;

    // flags byte of status and result replies
    typedef struct packed {
        logic [5:0] padding;
        logic       conv_complete;
        logic       error;
    } status_flags_t;

    // IDENTIFY payload, byte 0 of the payload sits in the low bits
    typedef struct packed {
        logic [7:0] sensor_version;
        logic [7:0] core_version;
        logic [7:0] adapter_version;
        logic [7:0] protocol_version;
    } identify_args_t;

    // status / GET_RESULT payload, same byte ordering as above
    typedef struct packed {
        logic [7:0]    padding;
        logic [7:0]    adc_high;
        logic [7:0]    adc_low;
        status_flags_t flags;
    } result_args_t;

    // one payload word, two encodings
    typedef union packed {
        identify_args_t identify;
        result_args_t   result;
    } reply_payload_u;

endpackage

`default_nettype wire

//--- logic/request_if.sv
// request bus
// a finished request as decoded by the receive side

`default_nettype none

interface request_if;
    import sensor_link_pkg::*;

    logic            done;
    logic            ok;
    logic [31:0]     magic;
    logic [7:0]      cmd;
    logic [3:0]      length;
    sensor_signals_t mask;
    sensor_signals_t value;

    modport source (output done, ok, magic, cmd, length, mask, value);
    modport sink   (input  done, ok, magic, cmd, length, mask, value);

endinterface

`default_nettype wire

//--- logic/reply_if.sv
// reply bus
// a reply order from the command handler to the transmit side

`default_nettype none

interface reply_if;
    import sensor_link_pkg::*;

    // one cycle strobe, the other fields are valid with it
    logic          send;
    logic [7:0]    cmd;
    status_flags_t flags;
    logic [15:0]   adc_value;

    modport source (output send, cmd, flags, adc_value);
    modport sink   (input  send, cmd, flags, adc_value);

endinterface

`default_nettype wire

//--- logic/request_buffer.sv
// request buffer
// collects the received bytes of one request, counts its length and
// flags receive errors, then hands the decoded fields on at end of frame

`default_nettype none
`include "sensor_link_settings.svh"

module request_buffer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_soc,
    input  logic       rx_eoc,
    input  logic       rx_error,
    input  logic       rx_data_valid,
    input  logic [7:0] rx_data,
    request_if.source  req
);

    // holds the header and arguments while the CRC bytes are only counted
    logic [7:0] rx_buffer [`SL_RX_BUFF_LEN];
    logic [3:0] rx_count;
    logic       err_seen;

    // each valid byte lands at the current count while there is room
    always_ff @(posedge clk) begin
        if (rx_data_valid && (rx_count < 4'(`SL_RX_BUFF_LEN))) begin
            rx_buffer[rx_count[2:0]] <= rx_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_count <= '0;
            err_seen <= 1'b0;
        end else if (rx_soc) begin
            // new frame
            rx_count <= '0;
            err_seen <= 1'b0;
        end else begin
            if (rx_error) begin
                err_seen <= 1'b1;
            end
            // counting goes on past the buffer so the CRC is included and stops at 15
            if (rx_data_valid && (rx_count != 4'hf)) begin
                rx_count <= rx_count + 4'd1;
            end
        end
    end

    // ============================================================
    // decoded request fields in little endian order
    // ============================================================
    assign req.done   = rx_eoc;
    // an error flagged on the eoc cycle itself is not in err_seen yet
    assign req.ok     = !err_seen && !rx_error;
    assign req.magic  = {rx_buffer[3], rx_buffer[2], rx_buffer[1], rx_buffer[0]};
    assign req.cmd    = rx_buffer[4];
    assign req.length = rx_count;
    // SET_SIGNAL arguments
    assign req.mask   = rx_buffer[5];
    assign req.value  = rx_buffer[6];

endmodule

`default_nettype wire

//--- logic/command_handler.sv
// command handler
// checks each finished request, drives the sensor control strobes and
// orders the reply with its status flags one cycle later

`default_nettype none
`include "sensor_link_settings.svh"

module command_handler (
    input  logic        clk,
    input  logic        rst_n,
    request_if.sink     req,
    reply_if.source     rep,
    output logic        set_strobe,
    output logic        clear_all,
    output logic        result_read,
    output logic [7:0]  mask,
    output logic [7:0]  value,
    input  logic        conv_complete,
    input  logic [15:0] captured_value
);
    import sensor_link_pkg::*;

    // clean frame with our magic, anything else is dropped silently
    logic          accept;
    logic          len_short;
    logic          len_set_signal;
    logic          is_identify;
    logic          is_set_signal;
    logic          is_get_result;
    logic          is_abort;
    logic          is_known;
    logic          send_q;
    logic [7:0]    cmd_q;
    status_flags_t flags_q;
    logic [15:0]   adc_q;

    assign accept = req.done && req.ok && (req.magic == `SL_MAGIC);

    // ============================================================
    // command decode, code and length must both match
    // ============================================================
    assign len_short      = (req.length == `SL_REQ_LEN_SHORT);
    assign len_set_signal = (req.length == `SL_REQ_LEN_SET_SIGNAL);

    assign is_identify   = (req.cmd == CMD_IDENTIFY) && len_short;
    assign is_set_signal = (req.cmd == CMD_SET_SIGNAL) && len_set_signal;
    assign is_get_result = (req.cmd == CMD_GET_RESULT) && len_short;
    assign is_abort      = (req.cmd == CMD_ABORT) && len_short;
    assign is_known      = is_identify || is_set_signal || is_get_result || is_abort;

    // strobes go out in the done cycle so the sensor reacts at the next edge
    assign set_strobe  = accept && is_set_signal;
    assign clear_all   = accept && is_abort;
    // only consume a result that is actually there
    assign result_read = accept && is_get_result && conv_complete;
    assign mask        = req.mask;
    assign value       = req.value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send_q <= 1'b0;
        end else begin
            send_q <= accept;
        end
    end

    // reply contents, sampled before this command's effect lands
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q                 <= req.cmd;
            flags_q.padding       <= '0;
            flags_q.error         <= !is_known;
            // abort reports a cleared result
            flags_q.conv_complete <= is_abort ? 1'b0 : conv_complete;
            if (is_get_result) begin
                adc_q <= captured_value;
            end
        end
    end

    assign rep.send      = send_q;
    assign rep.cmd       = cmd_q;
    assign rep.flags     = flags_q;
    assign rep.adc_value = adc_q;

endmodule

`default_nettype wire

//--- logic/sensor_control.sv
// sensor control
// holds the sensor and ADC control lines and captures the ADC result
// when a conversion completes while the ADC is enabled

`default_nettype none

module sensor_control (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        set_strobe,
    input  logic        clear_all,
    input  logic        result_read,
    input  logic        adc_conversion_complete,
    input  logic [7:0]  mask,
    input  logic [7:0]  value,
    input  logic [15:0] adc_value,
    output logic [7:0]  signals,
    output logic        conv_complete,
    output logic [15:0] captured_value
);
    import sensor_link_pkg::*;

    sensor_signals_t lines;
    sensor_signals_t lines_next;

    // masked update, unmasked lines hold their state
    always_comb begin
        lines_next       = (lines & ~mask) | (value & mask);
        lines_next.spare = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines          <= '0;
            conv_complete  <= 1'b0;
            captured_value <= '0;
        end else if (clear_all) begin
            // abort, everything off and result dropped
            lines          <= '0;
            conv_complete  <= 1'b0;
            captured_value <= '0;
        end else begin
            if (set_strobe) begin
                lines <= lines_next;
            end
            // a fresh conversion wins over a read in the same cycle
            if (adc_conversion_complete && lines.adc_enable) begin
                conv_complete  <= 1'b1;
                captured_value <= adc_value;
            end else if (result_read) begin
                conv_complete <= 1'b0;
            end
        end
    end

    assign signals = lines;

endmodule

`default_nettype wire

//--- logic/reply_sender.sv
// reply sender
// latches a reply order, builds the header and payload bytes and hands
// them to the protocol core one byte per tx_req

`default_nettype none
`include "sensor_link_settings.svh"

module reply_sender (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_req,
    reply_if.sink      rep,
    output logic [7:0] tx_data,
    output logic       tx_data_valid
);
    import sensor_link_pkg::*;

    logic [7:0]     cmd_q;
    status_flags_t  flags_q;
    logic [15:0]    adc_q;
    reply_payload_u payload;
    // payload, command, magic from high to low bytes
    logic [71:0]    reply_bytes;
    logic [3:0]     reply_len;
    logic [3:0]     tx_idx;
    logic           valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q   <= CMD_IDENTIFY;
            flags_q <= '0;
        end else if (rep.send) begin
            cmd_q   <= rep.cmd;
            flags_q <= rep.flags;
        end
    end

    always_ff @(posedge clk) begin
        if (rep.send) begin
            adc_q <= rep.adc_value;
        end
    end

    // ============================================================
    // reply encoding
    // ============================================================
    always_comb begin
        payload = '0;
        if ((cmd_q == CMD_IDENTIFY) && !flags_q.error) begin
            payload.identify.protocol_version = `SL_PROTOCOL_VERSION;
            payload.identify.adapter_version  = `SL_ADAPTER_VERSION;
            payload.identify.core_version     = `SL_CORE_VERSION;
            payload.identify.sensor_version   = `SL_SENSOR_VERSION;
        end else begin
            // status replies only send the flags byte of this view
            payload.result.flags    = flags_q;
            payload.result.adc_low  = adc_q[7:0];
            payload.result.adc_high = adc_q[15:8];
            payload.result.padding  = '0;
        end
    end

    // an error always gets the short status reply
    always_comb begin
        if (flags_q.error) begin
            reply_len = `SL_REPLY_LEN_STATUS;
        end else begin
            case (cmd_q)
                CMD_IDENTIFY:   reply_len = `SL_REPLY_LEN_IDENTIFY;
                CMD_GET_RESULT: reply_len = `SL_REPLY_LEN_RESULT;
                default:        reply_len = `SL_REPLY_LEN_STATUS;
            endcase
        end
    end

    assign reply_bytes = {payload, cmd_q, `SL_MAGIC};

    // the index never passes the last byte of the longest reply
    assign tx_data = reply_bytes[tx_idx * 8 +: 8];

    // ============================================================
    // byte handshake
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            tx_idx  <= '0;
        end else if (rep.send) begin
            // a new order restarts from the first byte
            valid_q <= 1'b1;
            tx_idx  <= '0;
        end else if (valid_q && tx_req) begin
            if ((tx_idx + 4'd1) == reply_len) begin
                valid_q <= 1'b0;
            end else begin
                tx_idx <= tx_idx + 4'd1;
            end
        end
    end

    assign tx_data_valid = valid_q;

endmodule

`default_nettype wire

//--- logic/sensor_link_top.sv
// sensor link top level
// command adapter between the contactless protocol core and the
// radiation sensor with its ADC

`default_nettype none

module sensor_link_top (
    input  logic        clk,
    input  logic        rst_n,
    // receive side of the protocol core
    input  logic        rx_soc,
    input  logic        rx_eoc,
    input  logic        rx_error,
    input  logic        rx_data_valid,
    input  logic [7:0]  rx_data,
    // transmit side of the protocol core
    input  logic        tx_req,
    output logic [7:0]  tx_data,
    output logic        tx_data_valid,
    // sensor and ADC
    output logic [2:0]  sens_config,
    output logic        sens_enable,
    output logic        sens_read,
    output logic        adc_enable,
    output logic        adc_read,
    input  logic        adc_conversion_complete,
    input  logic [15:0] adc_value
);
    import sensor_link_pkg::*;

    logic            set_strobe;
    logic            clear_all;
    logic            result_read;
    logic [7:0]      mask;
    logic [7:0]      value;
    logic            conv_complete;
    logic [15:0]     captured_value;
    sensor_signals_t signals;

    request_if req_bus ();
    reply_if   rep_bus ();

    request_buffer u_request_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_soc        (rx_soc),
        .rx_eoc        (rx_eoc),
        .rx_error      (rx_error),
        .rx_data_valid (rx_data_valid),
        .rx_data       (rx_data),
        .req           (req_bus.source)
    );

    command_handler u_command_handler (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req_bus.sink),
        .rep            (rep_bus.source),
        .set_strobe     (set_strobe),
        .clear_all      (clear_all),
        .result_read    (result_read),
        .mask           (mask),
        .value          (value),
        .conv_complete  (conv_complete),
        .captured_value (captured_value)
    );

    sensor_control u_sensor_control (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .set_strobe              (set_strobe),
        .clear_all               (clear_all),
        .result_read             (result_read),
        .adc_conversion_complete (adc_conversion_complete),
        .mask                    (mask),
        .value                   (value),
        .adc_value               (adc_value),
        .signals                 (signals),
        .conv_complete           (conv_complete),
        .captured_value          (captured_value)
    );

    reply_sender u_reply_sender (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_req        (tx_req),
        .rep           (rep_bus.sink),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid)
    );

    // control word out to the pins
    assign sens_config = signals.sens_config;
    assign sens_enable = signals.sens_enable;
    assign sens_read   = signals.sens_read;
    assign adc_enable  = signals.adc_enable;
    assign adc_read    = signals.adc_read;

endmodule

`default_nettype wire

//--- verification/sensor_link_tb.sv
// sensor link testbench
// drives requests from a table through the adapter, reads the replies
// with random tx_req gaps and checks reply bytes and sensor lines

`default_nettype none
`include "sensor_link_settings.svh"

module sensor_link_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 12;
    localparam int REPLY_WAIT   = 16;
    localparam int LONG_GAP     = 40;
    // request, ADC pulse, reply wait, then nine bytes at the longest gap
    localparam int ROW_CYCLES   = 20 + REPLY_WAIT + 9 * (LONG_GAP + 3);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + NUM_ROWS * ROW_CYCLES;

    localparam logic [31:0] MAGIC     = `SL_MAGIC;
    localparam logic [31:0] BAD_MAGIC = `SL_MAGIC ^ 32'h0000_0100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        rx_soc;
    logic        rx_eoc;
    logic        rx_error;
    logic        rx_data_valid;
    logic [7:0]  rx_data;
    logic        tx_req;
    logic [7:0]  tx_data;
    logic        tx_data_valid;
    logic [2:0]  sens_config;
    logic        sens_enable;
    logic        sens_read;
    logic        adc_enable;
    logic        adc_read;
    logic        adc_conversion_complete;
    logic [15:0] adc_value;

    int errors = 0;
    int checks = 0;

    // ============================================================
    // test table with one row per request
    // ============================================================
    string       test_name   [NUM_ROWS];
    logic [7:0]  req_bytes   [NUM_ROWS][12];
    int          req_len     [NUM_ROWS];
    bit          inject_err  [NUM_ROWS];
    bit          adc_event   [NUM_ROWS];
    logic [15:0] adc_sample  [NUM_ROWS];
    // exp_len of 0 means the request must be ignored
    logic [7:0]  exp_bytes   [NUM_ROWS][12];
    int          exp_len     [NUM_ROWS];
    logic [7:0]  exp_signals [NUM_ROWS];
    int          max_gap     [NUM_ROWS];

    sensor_link_top dut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .rx_soc                  (rx_soc),
        .rx_eoc                  (rx_eoc),
        .rx_error                (rx_error),
        .rx_data_valid           (rx_data_valid),
        .rx_data                 (rx_data),
        .tx_req                  (tx_req),
        .tx_data                 (tx_data),
        .tx_data_valid           (tx_data_valid),
        .sens_config             (sens_config),
        .sens_enable             (sens_enable),
        .sens_read               (sens_read),
        .adc_enable              (adc_enable),
        .adc_read                (adc_read),
        .adc_conversion_complete (adc_conversion_complete),
        .adc_value               (adc_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fills the row fields and leaves the row without a reply until set_reply runs
    task automatic set_row(input int row, input string name, input bit err, input bit adc,
                           input logic [15:0] sample, input logic [7:0] lines, input int gap);
        test_name[row]   = name;
        inject_err[row]  = err;
        adc_event[row]   = adc;
        adc_sample[row]  = sample;
        exp_signals[row] = lines;
        max_gap[row]     = gap;
        exp_len[row]     = 0;
    endtask

    // little endian magic and command followed by the arguments and two random CRC bytes
    task automatic set_request(input int row, input logic [31:0] magic, input logic [7:0] cmd,
                               input int nargs, input logic [7:0] arg0, input logic [7:0] arg1);
        int i;
        for (i = 0; i < 4; i++)
            req_bytes[row][i] = magic[i*8 +: 8];
        req_bytes[row][4] = cmd;
        req_bytes[row][5] = arg0;
        req_bytes[row][6] = arg1;
        for (i = 5 + nargs; i < 7 + nargs; i++)
            req_bytes[row][i] = 8'($urandom());
        req_len[row] = 7 + nargs;
    endtask

    // the header echoes the command and payload byte 0 sits in the low bits of the word
    task automatic set_reply(input int row, input logic [7:0] cmd, input int plen,
                             input logic [31:0] payload);
        int i;
        for (i = 0; i < 4; i++)
            exp_bytes[row][i] = MAGIC[i*8 +: 8];
        exp_bytes[row][4] = cmd;
        for (i = 0; i < plen; i++)
            exp_bytes[row][5 + i] = payload[i*8 +: 8];
        exp_len[row] = 5 + plen;
    endtask

    task automatic build_table();
        // identify returns the version bytes in protocol, adapter, core and sensor order
        set_row(0, "identify", 0, 0, 16'h0000, 8'h00, 3);
        set_request(0, MAGIC, 8'h00, 0, 8'h00, 8'h00);
        set_reply(0, 8'h00, 4, {`SL_SENSOR_VERSION, `SL_CORE_VERSION,
                                `SL_ADAPTER_VERSION, `SL_PROTOCOL_VERSION});
        // config 010 with sens_enable and adc_enable on
        set_row(1, "set_signal_mask", 0, 0, 16'h0000, 8'h2a, 3);
        set_request(1, MAGIC, 8'h01, 2, 8'h2b, 8'h2a);
        set_reply(1, 8'h01, 1, 32'h0000_0000);
        // sets config bits 0 and 2 and both read lines and clears config bit 1
        // the enables lie outside the mask and keep their state against a zero value
        set_row(2, "set_signal_keep", 0, 0, 16'h0000, 8'h7d, 3);
        set_request(2, MAGIC, 8'h01, 2, 8'h57, 8'hd5);
        set_reply(2, 8'h01, 1, 32'h0000_0000);
        set_row(3, "get_result_ready", 0, 1, 16'hbeef, 8'h7d, 3);
        set_request(3, MAGIC, 8'h03, 0, 8'h00, 8'h00);
        set_reply(3, 8'h03, 3, {8'h00, 8'hbe, 8'hef, 8'h02});
        // the completion flag is consumed and the value is still held
        set_row(4, "get_result_again", 0, 0, 16'h0000, 8'h7d, 3);
        set_request(4, MAGIC, 8'h03, 0, 8'h00, 8'h00);
        set_reply(4, 8'h03, 3, {8'h00, 8'hbe, 8'hef, 8'h00});
        set_row(5, "unknown_code", 0, 0, 16'h0000, 8'h7d, 3);
        set_request(5, MAGIC, 8'h02, 0, 8'h00, 8'h00);
        set_reply(5, 8'h02, 1, 32'h0000_0001);
        set_row(6, "identify_long", 0, 0, 16'h0000, 8'h7d, 3);
        set_request(6, MAGIC, 8'h00, 1, 8'h5a, 8'h00);
        set_reply(6, 8'h00, 1, 32'h0000_0001);
        // these two must be dropped without a trace
        set_row(7, "bad_magic", 0, 0, 16'h0000, 8'h7d, 3);
        set_request(7, BAD_MAGIC, 8'h00, 0, 8'h00, 8'h00);
        set_row(8, "rx_error", 1, 0, 16'h0000, 8'h7d, 3);
        set_request(8, MAGIC, 8'h01, 2, 8'hff, 8'h00);
        // a pending result is thrown away and reported clear
        set_row(9, "abort", 0, 1, 16'h1234, 8'h00, 3);
        set_request(9, MAGIC, 8'h04, 0, 8'h00, 8'h00);
        set_reply(9, 8'h04, 1, 32'h0000_0000);
        // adc_enable is off now so this conversion is not captured
        set_row(10, "get_result_cleared", 0, 1, 16'h5555, 8'h00, 3);
        set_request(10, MAGIC, 8'h03, 0, 8'h00, 8'h00);
        set_reply(10, 8'h03, 3, 32'h0000_0000);
        set_row(11, "back_pressure", 0, 0, 16'h0000, 8'h00, LONG_GAP);
        set_request(11, MAGIC, 8'h00, 0, 8'h00, 8'h00);
        set_reply(11, 8'h00, 4, {`SL_SENSOR_VERSION, `SL_CORE_VERSION,
                                 `SL_ADAPTER_VERSION, `SL_PROTOCOL_VERSION});
    endtask

    // ============================================================
    // bus tasks
    // ============================================================
    task automatic pulse_adc(input logic [15:0] sample);
        @(posedge clk);
        adc_conversion_complete <= 1'b1;
        adc_value               <= sample;
        @(posedge clk);
        adc_conversion_complete <= 1'b0;
    endtask

    // soc then one byte per cycle and finally eoc
    task automatic send_request(input int row);
        int i;
        @(posedge clk);
        rx_soc <= 1'b1;
        for (i = 0; i < req_len[row]; i++) begin
            @(posedge clk);
            rx_soc        <= 1'b0;
            rx_data_valid <= 1'b1;
            rx_data       <= req_bytes[row][i];
            rx_error      <= inject_err[row] && (i == 2);
        end
        @(posedge clk);
        rx_data_valid <= 1'b0;
        rx_error      <= 1'b0;
        rx_eoc        <= 1'b1;
        @(posedge clk);
        rx_eoc <= 1'b0;
    endtask

    // outputs are sampled on the falling edge
    task automatic read_reply(input int row);
        int i;
        int waited;
        int gap;
        waited = 0;
        @(negedge clk);
        while (!tx_data_valid && (waited < REPLY_WAIT)) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (exp_len[row] == 0) begin
            if (tx_data_valid) begin
                errors++;
                $display("%s: a reply was sent for a request that must be ignored",
                         test_name[row]);
            end
        end else if (!tx_data_valid) begin
            errors++;
            $display("%s: no reply arrived within %0d cycles", test_name[row], REPLY_WAIT);
        end else begin
            for (i = 0; i < exp_len[row]; i++) begin
                checks++;
                if (!tx_data_valid) begin
                    errors++;
                    $display("%s: tx_data_valid dropped before byte %0d", test_name[row], i);
                end else if (tx_data !== exp_bytes[row][i]) begin
                    errors++;
                    $display("Mismatch %s byte %0d: expected %02h, actual %02h",
                             test_name[row], i, exp_bytes[row][i], tx_data);
                end
                gap = $urandom_range(max_gap[row]);
                repeat (gap) @(posedge clk);
                @(posedge clk);
                tx_req <= 1'b1;
                @(posedge clk);
                tx_req <= 1'b0;
                @(negedge clk);
            end
            checks++;
            if (tx_data_valid) begin
                errors++;
                $display("%s: tx_data_valid stayed high after the last byte", test_name[row]);
            end
        end
    endtask

    task automatic run_row(input int row);
        logic [7:0] lines;
        if (adc_event[row])
            pulse_adc(adc_sample[row]);
        send_request(row);
        read_reply(row);
        @(negedge clk);
        lines = {1'b0, adc_read, adc_enable, sens_read, sens_enable, sens_config};
        checks++;
        if (lines !== exp_signals[row]) begin
            errors++;
            $display("Mismatch %s sensor lines: expected %02h, actual %02h",
                     test_name[row], exp_signals[row], lines);
        end
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================
    initial begin
        rst_n                   = 1'b0;
        rx_soc                  = 1'b0;
        rx_eoc                  = 1'b0;
        rx_error                = 1'b0;
        rx_data_valid           = 1'b0;
        rx_data                 = 8'h00;
        tx_req                  = 1'b0;
        adc_conversion_complete = 1'b0;
        adc_value               = 16'h0000;
        void'($urandom(32'h9af985dd));
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int row = 0; row < NUM_ROWS; row++)
            run_row(row);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all %0d rows were done", NUM_ROWS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/sensor_link_pkg.sv
logic/request_if.sv
logic/reply_if.sv
logic/request_buffer.sv
logic/command_handler.sv
logic/sensor_control.sv
logic/reply_sender.sv
logic/sensor_link_top.sv
verification/sensor_link_tb.sv

//--- Makefile
# Verilator build and run of the sensor link testbench

VERILATOR ?= verilator
TOP       ?= sensor_link_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_LINE ?= TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)
